//--- cop_lsu_top.f
src/cop_lsu_pkg.sv
src/cop_issue.sv
src/cop_cpr_file.sv
src/cop_mem.sv
src/cop_lsu_top.sv
testbench/tb_clock.sv
testbench/tb_mem_model.sv
testbench/tb_cop_lsu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cop_lsu
FILELIST  ?= cop_lsu_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_cop_lsu.sv
/*
 * Testbench for the coprocessor load/store path: stimulus table,
 * reference memory and CPR model, result checks and watchdog
 */
module tb_cop_lsu;
    import cop_lsu_pkg::*;

    typedef struct packed {
        logic [31:0] word;
        logic [31:0] rs1;
        logic        stall;
        logic [1:0]  err;   // 0 none, 1 addr, 2 bus, 3 illegal
        logic [2:0]  mv;
    } entry_t;

    logic         g_clk;
    logic         g_resetn;
    logic         instr_valid = 1'b0;
    logic [31:0]  instr_word = 32'h0;
    logic [31:0]  gpr_rs1 = 32'h0;
    logic [2:0]   mv_idx = 3'd0;
    logic         stall_en = 1'b0;
    logic         busy;
    logic         done;
    logic         addr_error;
    logic         bus_error;
    logic         illegal_error;
    logic [31:0]  mv_rdata;
    cop_mem_req_t mem_req;
    cop_mem_rsp_t mem_rsp;

    entry_t       tbl[$];
    logic [31:0]  ref_mem [256];
    logic [31:0]  ref_cpr [8];
    int           cen_count = 0;

    tb_clock clk_gen (.g_clk(g_clk), .g_resetn(g_resetn));

    tb_mem_model mem_model (
        .g_clk(g_clk), .g_resetn(g_resetn), .stall_en(stall_en),
        .req(mem_req), .rsp(mem_rsp)
    );

    cop_lsu_top DUT (
        .g_clk(g_clk), .g_resetn(g_resetn), .instr_valid(instr_valid),
        .instr_word(instr_word), .gpr_rs1(gpr_rs1), .mv_idx(mv_idx),
        .busy(busy), .done(done), .addr_error(addr_error), .bus_error(bus_error),
        .illegal_error(illegal_error), .mv_rdata(mv_rdata),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    always @(posedge g_clk) begin
        if (mem_req.cen)
            cen_count <= cen_count + 1;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] enc(input logic [3:0] op, input logic [2:0] crd,
                                        input logic [2:0] s2, input logic [2:0] s3,
                                        input logic [1:0] lane, input logic [11:0] imm);
        return {imm, 5'b0, lane, s3, s2, crd, op};
    endfunction

    task automatic add(input logic [31:0] word, input logic [31:0] rs1, input logic stall,
                       input logic [1:0] err, input logic [2:0] mv);
        tbl.push_back({word, rs1, stall, err, mv});
    endtask

    // Reference execution of one instruction, returns the error kind
    task automatic model_exec(input logic [31:0] word, input logic [31:0] rs1,
                              output logic [1:0] err);
        logic [3:0]  op;
        logic [2:0]  crd;
        logic [1:0]  lane;
        logic [31:0] imm;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] a;
        logic [31:0] w;
        logic [31:0] addrs [4];
        int          n;
        int          bs;
        int          hs;
        op   = word[3:0];
        crd  = word[6:4];
        lane = word[14:13];
        imm  = {{20{word[31]}}, word[31:20]};
        v2   = ref_cpr[word[9:7]];
        v3   = ref_cpr[word[12:10]];
        err  = 2'd0;
        if (op > 4'd9) begin
            err = 2'd3;
            return;
        end
        n = (op == 4'd6 || op == 4'd8) ? 4 : (op == 4'd7 || op == 4'd9) ? 2 : 1;
        for (int k = 0; k < n; k++) begin
            if (op == 4'd6 || op == 4'd8)
                addrs[k] = rs1 + {24'h0, v2[k*8 +: 8]};
            else if (op == 4'd7 || op == 4'd9)
                addrs[k] = rs1 + {16'h0, v2[k*16 +: 16]};
            else
                addrs[k] = rs1 + imm;
            if ((op == 4'd0 || op == 4'd3) && addrs[k][1:0] != 2'b00)
                err = 2'd1;
            if ((op == 4'd1 || op == 4'd4 || op == 4'd7 || op == 4'd9) && addrs[k][0])
                err = 2'd1;
        end
        if (err != 2'd0)
            return;
        for (int k = 0; k < n; k++) begin
            a = addrs[k];
            if (a >= 32'h400) begin
                err = 2'd2;  // Earlier accesses stand
                return;
            end
            w  = ref_mem[a[9:2]];
            bs = 8 * int'(a[1:0]);
            hs = 16 * int'(a[1]);
            case (op)
                4'd0: ref_cpr[crd] = w;
                4'd1: begin
                    if (lane[1])
                        ref_cpr[crd][31:16] = w[hs +: 16];
                    else
                        ref_cpr[crd] = {16'h0, w[hs +: 16]};
                end
                4'd2: begin
                    if (lane == 2'd0)
                        ref_cpr[crd] = {24'h0, w[bs +: 8]};
                    else
                        ref_cpr[crd][8*int'(lane) +: 8] = w[bs +: 8];
                end
                4'd3: ref_mem[a[9:2]] = v2;
                4'd4: ref_mem[a[9:2]][hs +: 16] = v2[16*int'(lane[1]) +: 16];
                4'd5: ref_mem[a[9:2]][bs +: 8] = v2[8*int'(lane) +: 8];
                4'd6: ref_cpr[crd][k*8 +: 8] = w[bs +: 8];
                4'd7: ref_cpr[crd][k*16 +: 16] = w[hs +: 16];
                4'd8: ref_mem[a[9:2]][bs +: 8] = v3[k*8 +: 8];
                default: ref_mem[a[9:2]][hs +: 16] = v3[k*16 +: 16];
            endcase
        end
    endtask

    task automatic build_table();
        for (int i = 0; i < 8; i++)
            add(enc(LD_W, i[2:0], 0, 0, 0, 12'(i * 4)), 32'h3c0, 0, 0, i[2:0]);
        add(enc(ST_W, 0, 4, 0, 0, 12'h010), 32'h100, 0, 0, 3'd4);
        add(enc(LD_W, 0, 0, 0, 0, 12'hffc), 32'h114, 0, 0, 3'd0);  // Negative imm
        add(enc(ST_H, 0, 5, 0, 2'b10, 12'h002), 32'h120, 0, 0, 3'd5);
        add(enc(ST_H, 0, 5, 0, 2'b00, 12'h004), 32'h120, 1, 0, 3'd5);
        add(enc(LD_H, 6, 0, 0, 2'b10, 12'h002), 32'h120, 0, 0, 3'd6);
        add(enc(LD_H, 6, 0, 0, 2'b00, 12'h006), 32'h120, 0, 0, 3'd6);
        add(enc(LD_H, 6, 0, 0, 2'b01, 12'h004), 32'h120, 0, 0, 3'd6);
        add(enc(ST_B, 0, 7, 0, 2'd1, 12'h003), 32'h130, 0, 0, 3'd7);
        add(enc(ST_B, 0, 7, 0, 2'd2, 12'h000), 32'h130, 0, 0, 3'd7);
        add(enc(ST_B, 0, 7, 0, 2'd3, 12'h001), 32'h130, 1, 0, 3'd7);
        add(enc(ST_B, 0, 7, 0, 2'd0, 12'h002), 32'h130, 0, 0, 3'd7);
        add(enc(LD_B, 5, 0, 0, 2'd1, 12'h000), 32'h130, 0, 0, 3'd5);
        add(enc(LD_B, 5, 0, 0, 2'd0, 12'h003), 32'h130, 0, 0, 3'd5);
        add(enc(LD_B, 5, 0, 0, 2'd2, 12'h002), 32'h130, 0, 0, 3'd5);
        add(enc(LD_B, 5, 0, 0, 2'd3, 12'h001), 32'h130, 1, 0, 3'd5);
        add(enc(SCATTER_B, 0, 1, 4, 0, 0), 32'h200, 0, 0, 3'd1);
        add(enc(GATHER_B, 6, 1, 0, 0, 0), 32'h200, 0, 0, 3'd6);
        add(enc(SCATTER_H, 0, 2, 5, 0, 0), 32'h240, 1, 0, 3'd5);
        add(enc(GATHER_H, 7, 2, 0, 0, 0), 32'h240, 0, 0, 3'd7);
        add(enc(LD_W, 3, 0, 0, 0, 12'h002), 32'h100, 0, 1, 3'd3);
        add(enc(ST_W, 0, 4, 0, 0, 12'h000), 32'h101, 0, 1, 3'd4);
        add(enc(LD_H, 5, 0, 0, 0, 12'h001), 32'h100, 0, 1, 3'd5);
        add(enc(ST_H, 0, 4, 0, 0, 12'h000), 32'h103, 1, 1, 3'd4);
        add(enc(SCATTER_H, 0, 3, 4, 0, 0), 32'h240, 0, 1, 3'd3);  // Odd offset
        add(enc(LD_W, 2, 0, 0, 0, 12'h000), 32'h400, 0, 2, 3'd2);
        add(enc(ST_B, 0, 4, 0, 0, 12'h000), 32'h500, 0, 2, 3'd4);
        add(enc(SCATTER_B, 0, 1, 5, 0, 0), 32'h3f8, 0, 2, 3'd5);  // Third access faults
        add(enc(GATHER_H, 7, 2, 0, 0, 0), 32'h3fc, 0, 2, 3'd7);
        add(enc(4'hc, 0, 0, 0, 0, 0), 32'h100, 0, 3, 3'd0);
        add(enc(4'hf, 1, 0, 0, 0, 0), 32'h100, 1, 3, 3'd1);
    endtask

    task automatic run_entry(input entry_t t, input logic stall_all);
        logic [1:0] exp_err;
        int         cen_before;
        int         waited;
        waited = 0;
        @(posedge g_clk);
        instr_valid <= 1'b1;
        instr_word  <= t.word;
        gpr_rs1     <= t.rs1;
        mv_idx      <= t.mv;
        stall_en    <= t.stall || stall_all;
        cen_before  = cen_count;
        @(posedge g_clk);  // Accept edge
        instr_valid <= 1'b0;
        model_exec(t.word, t.rs1, exp_err);
        check("model error kind", {30'h0, exp_err}, {30'h0, t.err});
        @(negedge g_clk);
        while (!done) begin
            check("busy", {31'h0, busy}, 32'h1);
            waited++;
            if (waited > 40) begin
                $display("done did not arrive for instruction %h", t.word);
                $display("test failed");
                $fatal(1);
            end
            @(negedge g_clk);
        end
        check("busy", {31'h0, busy}, 32'h1);
        check("addr_error", {31'h0, addr_error}, {31'h0, exp_err == 2'd1});
        check("bus_error", {31'h0, bus_error}, {31'h0, exp_err == 2'd2});
        check("illegal_error", {31'h0, illegal_error}, {31'h0, exp_err == 2'd3});
        @(negedge g_clk);  // After the completion edge
        check("busy", {31'h0, busy}, 32'h0);
        // Count now covers the done cycle too
        if (exp_err == 2'd1 || exp_err == 2'd3)
            check("cen cycles", cen_count - cen_before, 32'h0);
        check("mv_rdata", mv_rdata, ref_cpr[t.mv]);
        for (int i = 0; i < 256; i++)
            check($sformatf("mem[%0h]", i * 4), mem_model.mem[i], ref_mem[i]);
    endtask

    initial begin
        build_table();
        wait (g_resetn === 1'b1);
        for (int i = 0; i < 256; i++)
            ref_mem[i] = mem_model.mem[i];
        for (int i = 0; i < 8; i++)
            ref_cpr[i] = 32'h0;
        foreach (tbl[i])
            run_entry(tbl[i], 1'b0);
        foreach (tbl[i])
            run_entry(tbl[i], 1'b1);  // Second pass with random stalls
        $display("test passed");
        $finish;
    end

    // Watchdog sized from the table, both passes
    initial begin
        #1;
        #(tbl.size() * 40 * 4 * 2 + 200);
        $display("watchdog expired before the table finished");
        $display("test failed");
        $fatal(1);
    end
endmodule

//--- testbench/tb_mem_model.sv
/*
 * Word memory model for the coprocessor bus: byte-enabled writes,
 * pseudo-random stalls and an error region from 32'h400 up
 */
module tb_mem_model (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      stall_en,
    input  cop_lsu_pkg::cop_mem_req_t req,
    output cop_lsu_pkg::cop_mem_rsp_t rsp
);
    logic [31:0] mem [256];
    logic [31:0] rnd;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Pattern mixes all eight index bits
    function automatic logic [31:0] fill_word(input logic [7:0] i);
        return ({24'h0, i} * 32'h9e3779b1) ^ {i, ~i, 16'h5a3c};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i[7:0]);
        end
        mem[8'hf1] = 32'h0c0b0601;  // Byte offsets 1, 6, 11, 12
        mem[8'hf2] = 32'h00040002;  // Halfword offsets 2, 4
        mem[8'hf3] = 32'h00050002;  // Second offset odd
    end

    always @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp.stall <= 1'b0;
            rsp.error <= 1'b0;
            rsp.rdata <= 32'h0;
            rnd       <= 32'hb8bc7c85;
        end else if (req.cen) begin
            rnd <= xorshift(rnd);
            if (stall_en && rnd[1:0] == 2'b00) begin
                rsp.stall <= 1'b1;  // Request held, retried next cycle
                rsp.error <= 1'b0;
            end else begin
                rsp.stall <= 1'b0;
                rsp.error <= req.addr >= 32'h400;
                if (req.addr < 32'h400) begin
                    rsp.rdata <= mem[req.addr[9:2]];
                    for (int b = 0; b < 4; b++) begin
                        if (req.wen && req.ben[b])
                            mem[req.addr[9:2]][b*8 +: 8] <= req.wdata[b*8 +: 8];
                    end
                end
            end
        end else begin
            rsp.stall <= 1'b0;
            rsp.error <= 1'b0;
        end
    end
endmodule

//--- testbench/tb_clock.sv
/*
 * Testbench clock and reset generator
 */
module tb_clock (
    output logic g_clk,
    output logic g_resetn
);
    initial g_clk = 1'b0;
    always #2 g_clk = ~g_clk;  // Period 4

    initial begin
        g_resetn = 1'b0;
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;
    end
endmodule

//--- src/cop_lsu_top.sv
/*
 * Load/store path top level: issue stage, CPR file and memory unit
 */
module cop_lsu_top (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      instr_valid,
    input  logic [31:0]               instr_word,
    input  logic [31:0]               gpr_rs1,
    input  logic [2:0]                mv_idx,
    output logic                      busy,
    output logic                      done,
    output logic                      addr_error,
    output logic                      bus_error,
    output logic                      illegal_error,
    output logic [31:0]               mv_rdata,
    output cop_lsu_pkg::cop_mem_req_t mem_req,
    input  cop_lsu_pkg::cop_mem_rsp_t mem_rsp
);
    import cop_lsu_pkg::*;

    cop_instr_t  inst;
    logic        inst_valid;
    logic [31:0] base;
    logic [31:0] cpr_rs2;
    logic [31:0] cpr_rs3;
    cpr_wb_t     wb;
    logic        mem_idone;
    logic        mem_addr_error;
    logic        mem_bus_error;

    cop_issue u_issue (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .instr_valid    (instr_valid),
        .instr_word     (instr_word),
        .gpr_rs1        (gpr_rs1),
        .mem_idone      (mem_idone),
        .mem_addr_error (mem_addr_error),
        .mem_bus_error  (mem_bus_error),
        .busy           (busy),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .base           (base),
        .done           (done),
        .addr_error     (addr_error),
        .bus_error      (bus_error),
        .illegal_error  (illegal_error)
    );

    cop_cpr_file u_cpr_file (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .rs2_idx   (inst.crs2),
        .rs3_idx   (inst.crs3),
        .mv_idx    (mv_idx),
        .wb        (wb),
        .rs2_rdata (cpr_rs2),
        .rs3_rdata (cpr_rs3),
        .mv_rdata  (mv_rdata)
    );

    cop_mem u_mem (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .base       (base),
        .cpr_rs2    (cpr_rs2),
        .cpr_rs3    (cpr_rs3),
        .mem_rsp    (mem_rsp),
        .mem_req    (mem_req),
        .wb         (wb),
        .idone      (mem_idone),
        .addr_error (mem_addr_error),
        .bus_error  (mem_bus_error)
    );

endmodule

//--- src/cop_mem.sv
/*
 * Load/store unit: single word, halfword and byte accesses plus
 * byte/halfword scatter and gather, with lane steering and error checks
 */
module cop_mem (
    input  logic                      g_clk,
    input  logic                      g_resetn,
    input  logic                      inst_valid,
    input  cop_lsu_pkg::cop_instr_t   inst,
    input  logic [31:0]               base,
    input  logic [31:0]               cpr_rs2,
    input  logic [31:0]               cpr_rs3,
    input  cop_lsu_pkg::cop_mem_rsp_t mem_rsp,
    output cop_lsu_pkg::cop_mem_req_t mem_req,
    output cop_lsu_pkg::cpr_wb_t      wb,
    output logic                      idone,
    output logic                      addr_error,
    output logic                      bus_error
);
    import cop_lsu_pkg::*;

    mem_fsm_e    state_q;
    mem_fsm_e    state_d;
    logic        p_cen;        // Request presented last cycle
    logic [1:0]  p_addr_lsbs;  // Byte offset of that request

    logic        is_word;
    logic        is_half;
    logic        is_byte;
    logic        is_sg;
    logic        is_store;
    logic        rsp_taken;
    logic        txn_good;
    logic        misaligned;
    logic [1:0]  lsb_sum;
    logic [1:0]  req_k;        // Access index being requested
    logic [1:0]  rsp_k;        // Access index being answered
    logic [31:0] offset;
    logic [31:0] addr;

    logic [31:0] st_src;
    logic [1:0]  st_byte_sel;
    logic        st_half_sel;
    logic [7:0]  st_byte;
    logic [15:0] st_half;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    logic [1:0]  wb_byte_lane;
    logic        wb_half_hi;
    logic [31:0] ld_data;
    logic [3:0]  ld_ben;

    // Access number that a sequencing state stands for
    function automatic logic [1:0] seq_index(input mem_fsm_e s);
        case (s)
            B1, H1:  return 2'd1;
            B2:      return 2'd2;
            B3:      return 2'd3;
            default: return 2'd0;
        endcase
    endfunction

    assign is_word  = inst.op inside {LD_W, ST_W};
    assign is_half  = inst.op inside {LD_H, ST_H, GATHER_H, SCATTER_H};
    assign is_byte  = inst.op inside {LD_B, ST_B, GATHER_B, SCATTER_B};
    assign is_sg    = inst.op inside {GATHER_B, GATHER_H, SCATTER_B, SCATTER_H};
    assign is_store = inst.op inside {ST_W, ST_H, ST_B, SCATTER_B, SCATTER_H};

    assign rsp_taken = inst_valid && p_cen && !mem_rsp.stall;
    assign txn_good  = rsp_taken && !mem_rsp.error;
    assign bus_error = rsp_taken && mem_rsp.error;

    // Alignment from adder inputs so it never depends on the FSM
    assign lsb_sum = base[1:0] + inst.imm[1:0];

    always_comb begin
        if (is_word)
            misaligned = lsb_sum != 2'b00;
        else if (is_half && !is_sg)
            misaligned = base[0] ^ inst.imm[0];
        else if (is_half)
            misaligned = (base[0] ^ cpr_rs2[0]) || (base[0] ^ cpr_rs2[16]);
        else
            misaligned = 1'b0;  // Bytes never fault
    end

    // Checked before the first access only, gathers may rewrite rs2 later
    assign addr_error = inst_valid && state_q == IDLE && misaligned;

    always_comb begin
        state_d = state_q;
        if (bus_error) begin
            state_d = IDLE;     // Drop the remaining accesses
        end else if (txn_good) begin
            case (state_q)
                IDLE:    state_d = !is_sg ? IDLE : (is_byte ? B1 : H1);
                B1:      state_d = B2;
                B2:      state_d = B3;
                default: state_d = IDLE;
            endcase
        end
    end

    assign idone = addr_error || bus_error || (txn_good && state_d == IDLE);

    // Next request overlaps the current response
    assign req_k = seq_index(state_d);
    assign rsp_k = seq_index(state_q);

    always_comb begin
        if (!is_sg)
            offset = {{20{inst.imm[11]}}, inst.imm};
        else if (is_byte)
            offset = {24'h0, cpr_rs2[{req_k, 3'b000} +: 8]};
        else
            offset = {16'h0, cpr_rs2[{req_k[0], 4'b0000} +: 16]};
    end

    assign addr = base + offset;

    // Store lane selection
    assign st_src      = is_sg ? cpr_rs3 : cpr_rs2;
    assign st_byte_sel = is_sg ? req_k : {inst.wb_h, inst.wb_b};
    assign st_half_sel = is_sg ? req_k[0] : inst.wb_h;
    assign st_byte     = st_src[{st_byte_sel, 3'b000} +: 8];
    assign st_half     = st_src[{st_half_sel, 4'b0000} +: 16];

    assign mem_req.cen   = inst_valid && !idone && !addr_error;
    assign mem_req.wen   = is_store;
    assign mem_req.addr  = {addr[31:2], 2'b00};

    always_comb begin
        if (is_word) begin
            mem_req.wdata = cpr_rs2;
            mem_req.ben   = 4'b1111;
        end else if (is_half) begin
            mem_req.wdata = {16'h0, st_half} << {addr[1], 4'b0000};
            mem_req.ben   = addr[1] ? 4'b1100 : 4'b0011;
        end else begin
            mem_req.wdata = {24'h0, st_byte} << {addr[1:0], 3'b000};
            mem_req.ben   = 4'b0001 << addr[1:0];
        end
        if (!is_store)
            mem_req.ben = 4'b0000;
    end

    // Load lane extraction from the offset captured at request time
    assign ld_byte      = mem_rsp.rdata[{p_addr_lsbs, 3'b000} +: 8];
    assign ld_half      = p_addr_lsbs[1] ? mem_rsp.rdata[31:16] : mem_rsp.rdata[15:0];
    assign wb_byte_lane = is_sg ? rsp_k : {inst.wb_h, inst.wb_b};
    assign wb_half_hi   = is_sg ? rsp_k[0] : inst.wb_h;

    always_comb begin
        if (is_word) begin
            ld_data = mem_rsp.rdata;
            ld_ben  = 4'b1111;
        end else if (is_half) begin
            ld_data = {2{ld_half}};
            ld_ben  = wb_half_hi ? 4'b1100 : 4'b0011;
            if (!is_sg && !wb_half_hi) begin
                ld_data = {16'h0, ld_half};  // LD_H to low half clears the top
                ld_ben  = 4'b1111;
            end
        end else begin
            ld_data = {4{ld_byte}};
            ld_ben  = 4'b0001 << wb_byte_lane;
            if (!is_sg && wb_byte_lane == 2'd0) begin
                ld_data = {24'h0, ld_byte};
                ld_ben  = 4'b1111;
            end
        end
    end

    assign wb.ben   = (txn_good && !is_store) ? ld_ben : 4'b0000;
    assign wb.idx   = inst.crd;
    assign wb.wdata = ld_data;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state_q <= IDLE;
            p_cen   <= 1'b0;
        end else begin
            state_q <= state_d;
            p_cen   <= mem_req.cen;
        end
    end

    always_ff @(posedge g_clk) begin
        if (mem_req.cen)
            p_addr_lsbs <= addr[1:0];
    end

    // Address errors come before any access of the instruction
    a_addr_err_first: assert property (@(posedge g_clk) disable iff (!g_resetn)
        addr_error |-> !mem_req.cen && !p_cen);

    // Sequencing only runs under a held instruction
    a_fsm_needs_valid: assert property (@(posedge g_clk) disable iff (!g_resetn)
        state_q != IDLE |-> $past(inst_valid));

endmodule

//--- src/cop_cpr_file.sv
/*
 * Coprocessor register file: eight 32-bit CPRs, two operand read
 * ports, a move-to-core read port and a byte-enabled write port
 */
module cop_cpr_file (
    input  logic                               g_clk,
    input  logic                               g_resetn,
    input  logic [cop_lsu_pkg::CPR_IDX_W-1:0]  rs2_idx,
    input  logic [cop_lsu_pkg::CPR_IDX_W-1:0]  rs3_idx,
    input  logic [cop_lsu_pkg::CPR_IDX_W-1:0]  mv_idx,
    input  cop_lsu_pkg::cpr_wb_t               wb,
    output logic [31:0]                        rs2_rdata,
    output logic [31:0]                        rs3_rdata,
    output logic [31:0]                        mv_rdata
);
    import cop_lsu_pkg::*;

    logic [31:0] regs [CPR_COUNT];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < CPR_COUNT; i++) begin
                regs[i] <= 32'h0;
            end
        end else begin
            // Each byte lane written on its own enable
            for (int b = 0; b < 4; b++) begin
                if (wb.ben[b]) begin
                    regs[wb.idx][b*8 +: 8] <= wb.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Reads see the value before this cycle's write
    assign rs2_rdata = regs[rs2_idx];
    assign rs3_rdata = regs[rs3_idx];
    assign mv_rdata  = regs[mv_idx];   // Core side, combinational

endmodule

//--- src/cop_issue.sv
/*
 * Instruction issue stage: accepts a coprocessor memory instruction,
 * decodes and holds it until completion, reports illegal opcodes
 */
module cop_issue (
    input  logic                    g_clk,
    input  logic                    g_resetn,
    input  logic                    instr_valid,
    input  logic [31:0]             instr_word,
    input  logic [31:0]             gpr_rs1,
    input  logic                    mem_idone,
    input  logic                    mem_addr_error,
    input  logic                    mem_bus_error,
    output logic                    busy,
    output logic                    inst_valid,
    output cop_lsu_pkg::cop_instr_t inst,
    output logic [31:0]             base,
    output logic                    done,
    output logic                    addr_error,
    output logic                    bus_error,
    output logic                    illegal_error
);
    import cop_lsu_pkg::*;

    logic [3:0]  op_raw;
    logic        op_legal;
    logic        accept;
    cop_instr_t  dec;
    logic        busy_q;
    logic        valid_q;    // Legal instruction handed to memory unit
    logic        illegal_q;  // Completes next cycle with illegal_error
    cop_instr_t  inst_q;
    logic [31:0] base_q;

    assign op_raw   = instr_word[OP_MSB:OP_LSB];
    assign op_legal = op_raw inside {LD_W, LD_H, LD_B, ST_W, ST_H, ST_B,
                                     GATHER_B, GATHER_H, SCATTER_B, SCATTER_H};
    assign accept   = instr_valid && !busy_q;

    // Field extraction
    assign dec.op   = cop_op_e'(op_raw);
    assign dec.crd  = instr_word[CRD_LSB +: CPR_IDX_W];
    assign dec.crs2 = instr_word[CRS2_LSB +: CPR_IDX_W];
    assign dec.crs3 = instr_word[CRS3_LSB +: CPR_IDX_W];
    assign dec.wb_h = instr_word[WB_H_BIT];
    assign dec.wb_b = instr_word[WB_B_BIT];
    assign dec.imm  = instr_word[IMM_MSB:IMM_LSB];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy_q    <= 1'b0;
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else if (accept) begin
            busy_q    <= 1'b1;
            valid_q   <= op_legal;
            illegal_q <= !op_legal;
        end else if (done) begin
            busy_q    <= 1'b0;
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
        end
    end

    // Held until done
    always_ff @(posedge g_clk) begin
        if (accept) begin
            inst_q <= dec;
            base_q <= gpr_rs1;
        end
    end

    assign busy          = busy_q;
    assign inst_valid    = valid_q;
    assign inst          = inst_q;
    assign base          = base_q;
    assign done          = illegal_q || (valid_q && mem_idone);
    assign addr_error    = valid_q && mem_addr_error;
    assign bus_error     = valid_q && mem_bus_error;
    assign illegal_error = illegal_q;

    // An instruction in flight is neither dropped nor replaced
    a_held_until_done: assert property (@(posedge g_clk) disable iff (!g_resetn)
        busy && !done |=> busy && $stable(inst) && $stable(base));

    a_done_in_busy: assert property (@(posedge g_clk) disable iff (!g_resetn)
        done |-> busy);

endmodule

//--- src/cop_lsu_pkg.sv
/*
 * Shared types of the coprocessor load/store path: memory opcodes,
 * sequencing states, held instruction, bus and writeback structs
 */
package cop_lsu_pkg;

    // Register file geometry, fixed by the ISA
    localparam int CPR_COUNT = 8;
    localparam int CPR_IDX_W = 3;

    // Instruction word field positions
    localparam int OP_LSB   = 0;
    localparam int OP_MSB   = 3;
    localparam int CRD_LSB  = 4;
    localparam int CRS2_LSB = 7;
    localparam int CRS3_LSB = 10;
    localparam int WB_B_BIT = 13;
    localparam int WB_H_BIT = 14;
    localparam int IMM_LSB  = 20;
    localparam int IMM_MSB  = 31;

    // Memory opcodes, remaining codes are illegal
    typedef enum logic [3:0] {
        LD_W      = 4'd0,
        LD_H      = 4'd1,
        LD_B      = 4'd2,
        ST_W      = 4'd3,
        ST_H      = 4'd4,
        ST_B      = 4'd5,
        GATHER_B  = 4'd6,
        GATHER_H  = 4'd7,
        SCATTER_B = 4'd8,
        SCATTER_H = 4'd9
    } cop_op_e;

    // Scatter/gather sequencing
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        B1   = 3'd1,  // Byte access 1 in flight
        B2   = 3'd2,
        B3   = 3'd3,
        H1   = 3'd4   // Second halfword access
    } mem_fsm_e;

    typedef struct packed {
        cop_op_e                    op;
        logic [CPR_IDX_W-1:0]       crd;
        logic [CPR_IDX_W-1:0]       crs2;
        logic [CPR_IDX_W-1:0]       crs3;
        logic                       wb_h;  // Halfword lane select
        logic                       wb_b;  // Byte lane select
        logic [IMM_MSB-IMM_LSB:0]   imm;
    } cop_instr_t;

    typedef struct packed {
        logic        cen;
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  ben;
    } cop_mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        stall;
        logic        error;
    } cop_mem_rsp_t;

    typedef struct packed {
        logic [3:0]           ben;
        logic [CPR_IDX_W-1:0] idx;
        logic [31:0]          wdata;
    } cpr_wb_t;

endpackage
